// ==== soc_periph.f ====
+incdir+hw
hw/soc_periph_pkg.sv
hw/apb_periph_decoder.sv
hw/gpio_regs.sv
hw/gpio_core.sv
hw/soc_ctrl_regs.sv
hw/fc_event_map.sv
hw/soc_periph.sv
bench/tb_clock_gen.sv
bench/tb_soc_periph.sv

// ==== Makefile ====
# Verilator build and run of the soc_periph testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= soc_periph.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_soc_periph.sv ====
/*
 * Testbench of soc_periph. Inputs change on the falling clock edge and APB
 * responses are sampled a few ns later, inside the access phase.
 */
`timescale 1ns/10ps

`include "soc_periph_settings.svh"

module tb_soc_periph
    import soc_periph_pkg::*;
;

    localparam int SETTLE_NS   = 5;
    localparam int WAIT_LIMIT  = 20;
    localparam int WATCHDOG_NS = 1000000;

    logic          clk;
    logic          arst_n;
    logic          slow_clk;
    apb_addr_t     paddr;
    apb_data_t     pwdata;
    logic          pwrite;
    logic          psel;
    logic          penable;
    apb_data_t     prdata;
    logic          pready;
    logic          pslverr;
    gpio_vec_t     gpio_in;
    gpio_vec_t     gpio_out;
    gpio_vec_t     gpio_dir;
    apb_addr_t     fc_bootaddr;
    logic          fc_fetchen;
    jtag_byte_t    jtag_in;
    jtag_byte_t    jtag_out;
    logic          dma_pe_evt;
    logic          dma_pe_irq;
    logic          pf_evt;
    fc_event_vec_t fc_events;

    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_errors_base = 0;
    int gpio_pulse_cycles = 0;
    int ref_pulse_cycles = 0;

    tb_clock_gen tb_clock_gen_inst (
        .clk_o    ( clk    ),
        .arst_n_o ( arst_n )
    );

    soc_periph soc_periph_inst (
        .clk_i          ( clk         ),
        .arst_n_i       ( arst_n      ),
        .slow_clk_i     ( slow_clk    ),
        .paddr_i        ( paddr       ),
        .pwdata_i       ( pwdata      ),
        .pwrite_i       ( pwrite      ),
        .psel_i         ( psel        ),
        .penable_i      ( penable     ),
        .prdata_o       ( prdata      ),
        .pready_o       ( pready      ),
        .pslverr_o      ( pslverr     ),
        .gpio_in_i      ( gpio_in     ),
        .gpio_out_o     ( gpio_out    ),
        .gpio_dir_o     ( gpio_dir    ),
        .fc_bootaddr_o  ( fc_bootaddr ),
        .fc_fetchen_o   ( fc_fetchen  ),
        .soc_jtag_reg_i ( jtag_in     ),
        .soc_jtag_reg_o ( jtag_out    ),
        .dma_pe_evt_i   ( dma_pe_evt  ),
        .dma_pe_irq_i   ( dma_pe_irq  ),
        .pf_evt_i       ( pf_evt      ),
        .fc_events_o    ( fc_events   )
    );

    // Event bits come from flops, so they are stable at the falling edge
    always @(negedge clk) begin
        if (fc_events[`SOC_PERIPH_EVT_GPIO]) gpio_pulse_cycles++;
        if (fc_events[`SOC_PERIPH_EVT_REF_CLK]) ref_pulse_cycles++;
    end

    ////////////////////
    // Checking
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error @%0t ns: %s expected 32'h%08h, got 32'h%08h",
                     $time, name, exp, got);
            error_count++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("Failure @%0t ns: %s", $time, what);
        error_count++;
    endtask

    task automatic finish_test(input string name);
        int errors;
        errors = error_count - test_errors_base;
        tests_run++;
        if (errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAILED with %0d errors", name, errors);
            tests_failed++;
        end
        test_errors_base = error_count;
    endtask

    ////////////////////
    // APB access
    ////////////////////

    function automatic apb_addr_t region_addr(input logic [3:0] region,
                                              input logic [11:0] offs);
        apb_addr_t addr;
        addr = '0;
        addr[`SOC_PERIPH_REGION_MSB:`SOC_PERIPH_REGION_LSB] = region;
        addr[`SOC_PERIPH_REGION_LSB-1:0] = offs;
        return addr;
    endfunction

    function automatic apb_addr_t gpio_reg(input logic [11:0] offs);
        return region_addr(`SOC_PERIPH_REGION_GPIO, offs);
    endfunction

    function automatic apb_addr_t ctrl_reg(input logic [11:0] offs);
        return region_addr(`SOC_PERIPH_REGION_CTRL, offs);
    endfunction

    task automatic apb_transfer(input logic write, input apb_addr_t addr,
                                input apb_data_t wdata, output apb_data_t rdata,
                                output logic slverr);
        int cycles;
        @(negedge clk);
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = write;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #SETTLE_NS;
        cycles = 0;
        while (pready !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            #SETTLE_NS;
            cycles++;
        end
        if (pready !== 1'b1) note_failure("APB access phase never saw pready");
        rdata  = prdata;
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t rdata;
        logic      slverr;
        apb_transfer(1'b1, addr, data, rdata, slverr);
        check_value("pslverr_o (write)", 32'(slverr), 32'd0);
    endtask

    task automatic read_check(input apb_addr_t addr, input apb_data_t exp,
                              input string name);
        apb_data_t rdata;
        logic      slverr;
        apb_transfer(1'b0, addr, '0, rdata, slverr);
        check_value("pslverr_o (read)", 32'(slverr), 32'd0);
        check_value(name, rdata, exp);
    endtask

    ////////////////////
    // Waits
    ////////////////////

    function automatic int pulse_count(input logic ref_line);
        return ref_line ? ref_pulse_cycles : gpio_pulse_cycles;
    endfunction

    task automatic wait_pulses(input logic ref_line, input int target, input int limit,
                               input string what);
        int cycles;
        cycles = 0;
        while (pulse_count(ref_line) < target && cycles < limit) begin
            @(negedge clk);
            #SETTLE_NS;
            cycles++;
        end
        if (pulse_count(ref_line) < target) note_failure({what, " did not arrive in time"});
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1 && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) note_failure("reset was never released");
        @(negedge clk);
        #SETTLE_NS;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_state();
        check_value("gpio_out_o", gpio_out, 32'd0);
        check_value("gpio_dir_o", gpio_dir, 32'd0);
        check_value("fc_fetchen_o", 32'(fc_fetchen), 32'd0);
        check_value("soc_jtag_reg_o", 32'(jtag_out), 32'd0);
        check_value("fc_bootaddr_o", fc_bootaddr, `SOC_PERIPH_BOOT_ADDR_RST);
        check_value("fc_events_o", fc_events, 32'd0);
        check_value("pready_o", 32'(pready), 32'd1);
        finish_test("reset_state");
    endtask

    task automatic test_ctrl_regs();
        apb_addr_t  boot;
        jtag_byte_t out_byte;
        apb_data_t  wdata;
        boot = $urandom;
        reg_write(ctrl_reg(`SOC_PERIPH_CTRL_BOOTADDR), boot);
        check_value("fc_bootaddr_o", fc_bootaddr, boot);
        read_check(ctrl_reg(`SOC_PERIPH_CTRL_BOOTADDR), boot, "prdata_o (BOOTADDR)");
        // Only bit 0 of the fetch enable word is kept
        reg_write(ctrl_reg(`SOC_PERIPH_CTRL_FETCHEN), $urandom | 32'h1);
        check_value("fc_fetchen_o", 32'(fc_fetchen), 32'd1);
        read_check(ctrl_reg(`SOC_PERIPH_CTRL_FETCHEN), 32'd1, "prdata_o (FETCHEN)");
        reg_write(ctrl_reg(`SOC_PERIPH_CTRL_FETCHEN), $urandom & ~32'h1);
        check_value("fc_fetchen_o", 32'(fc_fetchen), 32'd0);
        jtag_in  = jtag_byte_t'($urandom);
        wdata    = $urandom;
        out_byte = wdata[7:0];
        reg_write(ctrl_reg(`SOC_PERIPH_CTRL_JTAG), wdata);
        check_value("soc_jtag_reg_o", 32'(jtag_out), 32'(out_byte));
        read_check(ctrl_reg(`SOC_PERIPH_CTRL_JTAG), {16'd0, jtag_in, out_byte},
                   "prdata_o (JTAG)");
        finish_test("ctrl_regs");
    endtask

    task automatic test_gpio_io();
        gpio_vec_t dir_val;
        gpio_vec_t out_val;
        gpio_vec_t in_val;
        dir_val = $urandom;
        out_val = $urandom;
        in_val  = $urandom;
        reg_write(gpio_reg(`SOC_PERIPH_GPIO_DIR), dir_val);
        reg_write(gpio_reg(`SOC_PERIPH_GPIO_OUT), out_val);
        check_value("gpio_dir_o", gpio_dir, dir_val);
        check_value("gpio_out_o", gpio_out, out_val);
        read_check(gpio_reg(`SOC_PERIPH_GPIO_DIR), dir_val, "prdata_o (DIR)");
        read_check(gpio_reg(`SOC_PERIPH_GPIO_OUT), out_val, "prdata_o (OUT)");
        @(negedge clk);
        gpio_in = in_val;
        repeat (5) @(negedge clk);
        read_check(gpio_reg(`SOC_PERIPH_GPIO_IN), in_val, "prdata_o (IN)");
        finish_test("gpio_io");
    endtask

    task automatic test_gpio_irq();
        int        rise_pin;
        int        fall_pin;
        int        off_pin;
        int        base;
        gpio_vec_t exp_status;
        rise_pin   = int'($urandom % 30);
        fall_pin   = rise_pin + 1;
        off_pin    = rise_pin + 2;
        exp_status = (gpio_vec_t'(1) << rise_pin) | (gpio_vec_t'(1) << fall_pin);
        // Falling pin starts high so it has an edge to give
        @(negedge clk);
        gpio_in = gpio_vec_t'(1) << fall_pin;
        repeat (5) @(negedge clk);
        reg_write(gpio_reg(`SOC_PERIPH_GPIO_INTTYPE), gpio_vec_t'(1) << fall_pin);
        reg_write(gpio_reg(`SOC_PERIPH_GPIO_INTEN), exp_status);
        base = gpio_pulse_cycles;
        @(negedge clk);
        gpio_in[rise_pin] = 1'b1;
        wait_pulses(1'b0, base + 1, 6, "GPIO rising edge event");
        @(negedge clk);
        gpio_in[fall_pin] = 1'b0;
        wait_pulses(1'b0, base + 2, 6, "GPIO falling edge event");
        @(negedge clk);
        gpio_in[off_pin] = 1'b1;
        repeat (5) @(negedge clk);
        gpio_in[off_pin] = 1'b0;
        repeat (5) @(negedge clk);
        #SETTLE_NS;
        check_value("fc_events_o[15] pulse cycles", 32'(gpio_pulse_cycles), 32'(base + 2));
        read_check(gpio_reg(`SOC_PERIPH_GPIO_INTSTATUS), exp_status, "prdata_o (INTSTATUS)");
        read_check(gpio_reg(`SOC_PERIPH_GPIO_INTSTATUS), 32'd0, "prdata_o (INTSTATUS cleared)");
        finish_test("gpio_irq");
    endtask

    task automatic test_events();
        int            base;
        fc_event_vec_t exp_evt;
        base = ref_pulse_cycles;
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            slow_clk = ~slow_clk;
            wait_pulses(1'b1, base + i + 1, 4, "slow clock edge event");
            repeat (4) @(negedge clk);
        end
        #SETTLE_NS;
        check_value("fc_events_o[14] pulse cycles", 32'(ref_pulse_cycles), 32'(base + 4));
        // Every combination of the pass-through lines
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            {pf_evt, dma_pe_irq, dma_pe_evt} = 3'(i);
            #SETTLE_NS;
            exp_evt = '0;
            exp_evt[`SOC_PERIPH_EVT_DMA_PE]  = dma_pe_evt;
            exp_evt[`SOC_PERIPH_EVT_DMA_IRQ] = dma_pe_irq;
            exp_evt[`SOC_PERIPH_EVT_PF]      = pf_evt;
            check_value("fc_events_o", fc_events, exp_evt);
        end
        @(negedge clk);
        {pf_evt, dma_pe_irq, dma_pe_evt} = 3'd0;
        finish_test("events");
    endtask

    task automatic test_unmapped();
        apb_addr_t unmapped;
        apb_data_t rdata;
        logic      slverr;
        gpio_vec_t dir_before;
        apb_addr_t boot_before;
        unmapped    = region_addr(4'd2, 12'h000);
        dir_before  = gpio_dir;
        boot_before = fc_bootaddr;
        apb_transfer(1'b0, unmapped, '0, rdata, slverr);
        check_value("pslverr_o (unmapped read)", 32'(slverr), 32'd1);
        check_value("prdata_o (unmapped read)", rdata, 32'd0);
        apb_transfer(1'b1, unmapped, $urandom, rdata, slverr);
        check_value("pslverr_o (unmapped write)", 32'(slverr), 32'd1);
        check_value("gpio_dir_o", gpio_dir, dir_before);
        check_value("fc_bootaddr_o", fc_bootaddr, boot_before);
        read_check(gpio_reg(`SOC_PERIPH_GPIO_DIR), dir_before, "prdata_o (DIR)");
        read_check(ctrl_reg(`SOC_PERIPH_CTRL_BOOTADDR), boot_before, "prdata_o (BOOTADDR)");
        finish_test("unmapped");
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        void'($urandom(32'h66de));
        slow_clk   = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        pwrite     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        gpio_in    = '0;
        jtag_in    = '0;
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        pf_evt     = 1'b0;
        wait_for_reset();
        test_reset_state();
        test_ctrl_regs();
        test_gpio_io();
        test_gpio_irq();
        test_events();
        test_unmapped();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Simulation ran past its time limit");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== bench/tb_clock_gen.sv ====
/*
 * Testbench clock of 40 ns period; reset is held low for 16 cycles.
 */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the active clock edge
    initial begin
        arst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

// ==== hw/soc_periph.sv ====
/*
 * SoC peripheral block behind one zero wait state APB slave port.
 * Region 0 is GPIO, region 1 is SoC control; all other regions give pslverr.
 */
`timescale 1ns/10ps

module soc_periph
    import soc_periph_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  logic          slow_clk_i,

    // APB slave port
    input  apb_addr_t     paddr_i,
    input  apb_data_t     pwdata_i,
    input  logic          pwrite_i,
    input  logic          psel_i,
    input  logic          penable_i,
    output apb_data_t     prdata_o,
    output logic          pready_o,
    output logic          pslverr_o,

    input  gpio_vec_t     gpio_in_i,
    output gpio_vec_t     gpio_out_o,
    output gpio_vec_t     gpio_dir_o,

    output apb_addr_t     fc_bootaddr_o,
    output logic          fc_fetchen_o,
    input  jtag_byte_t    soc_jtag_reg_i,
    output jtag_byte_t    soc_jtag_reg_o,

    input  logic          dma_pe_evt_i,
    input  logic          dma_pe_irq_i,
    input  logic          pf_evt_i,
    output fc_event_vec_t fc_events_o
);

    logic      gpio_sel;
    logic      ctrl_sel;
    apb_data_t gpio_rdata;
    apb_data_t ctrl_rdata;

    gpio_vec_t gpio_sync;
    gpio_vec_t gpio_status;
    gpio_vec_t gpio_inten;
    gpio_vec_t gpio_inttype;
    logic      gpio_status_clr;
    logic      gpio_event;

    ////////////////////
    // Bus decode
    ////////////////////

    apb_periph_decoder apb_periph_decoder_inst (
        .paddr_i      ( paddr_i    ),
        .psel_i       ( psel_i     ),
        .penable_i    ( penable_i  ),
        .gpio_rdata_i ( gpio_rdata ),
        .ctrl_rdata_i ( ctrl_rdata ),
        .gpio_sel_o   ( gpio_sel   ),
        .ctrl_sel_o   ( ctrl_sel   ),
        .prdata_o     ( prdata_o   ),
        .pready_o     ( pready_o   ),
        .pslverr_o    ( pslverr_o  )
    );

    ////////////////////
    // GPIO
    ////////////////////

    gpio_regs gpio_regs_inst (
        .clk_i        ( clk_i           ),
        .arst_n_i     ( arst_n_i        ),
        .sel_i        ( gpio_sel        ),
        .penable_i    ( penable_i       ),
        .pwrite_i     ( pwrite_i        ),
        .paddr_i      ( paddr_i         ),
        .pwdata_i     ( pwdata_i        ),
        .gpio_sync_i  ( gpio_sync       ),
        .status_i     ( gpio_status     ),
        .rdata_o      ( gpio_rdata      ),
        .dir_o        ( gpio_dir_o      ),
        .out_o        ( gpio_out_o      ),
        .inten_o      ( gpio_inten      ),
        .inttype_o    ( gpio_inttype    ),
        .status_clr_o ( gpio_status_clr )
    );

    gpio_core gpio_core_inst (
        .clk_i        ( clk_i           ),
        .arst_n_i     ( arst_n_i        ),
        .gpio_in_i    ( gpio_in_i       ),
        .inten_i      ( gpio_inten      ),
        .inttype_i    ( gpio_inttype    ),
        .status_clr_i ( gpio_status_clr ),
        .gpio_sync_o  ( gpio_sync       ),
        .status_o     ( gpio_status     ),
        .gpio_event_o ( gpio_event      )
    );

    ////////////////////
    // SoC control and events
    ////////////////////

    soc_ctrl_regs soc_ctrl_regs_inst (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .sel_i          ( ctrl_sel       ),
        .penable_i      ( penable_i      ),
        .pwrite_i       ( pwrite_i       ),
        .paddr_i        ( paddr_i        ),
        .pwdata_i       ( pwdata_i       ),
        .soc_jtag_reg_i ( soc_jtag_reg_i ),
        .rdata_o        ( ctrl_rdata     ),
        .fc_bootaddr_o  ( fc_bootaddr_o  ),
        .fc_fetchen_o   ( fc_fetchen_o   ),
        .soc_jtag_reg_o ( soc_jtag_reg_o )
    );

    fc_event_map fc_event_map_inst (
        .clk_i        ( clk_i        ),
        .arst_n_i     ( arst_n_i     ),
        .slow_clk_i   ( slow_clk_i   ),
        .gpio_event_i ( gpio_event   ),
        .dma_pe_evt_i ( dma_pe_evt_i ),
        .dma_pe_irq_i ( dma_pe_irq_i ),
        .pf_evt_i     ( pf_evt_i     ),
        .fc_events_o  ( fc_events_o  )
    );

endmodule

// ==== hw/fc_event_map.sv ====
/*
 * Fabric-controller event vector. The slow clock must be much slower than clk_i.
 * DMA and profiler events pass through without a register.
 */
`timescale 1ns/10ps

`include "soc_periph_settings.svh"

module fc_event_map
    import soc_periph_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  logic          slow_clk_i,
    input  logic          gpio_event_i,
    input  logic          dma_pe_evt_i,
    input  logic          dma_pe_irq_i,
    input  logic          pf_evt_i,

    output fc_event_vec_t fc_events_o
);

    logic slow_meta;
    logic slow_sync;
    logic slow_prev;
    logic ref_edge;

    ////////////////////
    // Slow clock edges
    ////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            slow_meta <= 1'b0;
            slow_sync <= 1'b0;
            slow_prev <= 1'b0;
        end else begin
            slow_meta <= slow_clk_i;
            slow_sync <= slow_meta;
            slow_prev <= slow_sync;
        end
    end

    // Rising and falling edges both count
    assign ref_edge = slow_sync ^ slow_prev;

    ////////////////////
    // Vector assembly
    ////////////////////

    always_comb begin
        fc_events_o = '0;
        fc_events_o[`SOC_PERIPH_EVT_DMA_PE]  = dma_pe_evt_i;
        fc_events_o[`SOC_PERIPH_EVT_DMA_IRQ] = dma_pe_irq_i;
        fc_events_o[`SOC_PERIPH_EVT_PF]      = pf_evt_i;
        fc_events_o[`SOC_PERIPH_EVT_REF_CLK] = ref_edge;
        fc_events_o[`SOC_PERIPH_EVT_GPIO]    = gpio_event_i;
    end

endmodule

// ==== hw/soc_ctrl_regs.sv ====
/*
 * Boot address, fetch enable and JTAG exchange registers.
 * The incoming JTAG byte is read as is and is not synchronized here.
 */
`timescale 1ns/10ps

`include "soc_periph_settings.svh"

module soc_ctrl_regs
    import soc_periph_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       sel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  apb_data_t  pwdata_i,
    input  jtag_byte_t soc_jtag_reg_i,

    output apb_data_t  rdata_o,
    output apb_addr_t  fc_bootaddr_o,
    output logic       fc_fetchen_o,
    output jtag_byte_t soc_jtag_reg_o
);

    logic [`SOC_PERIPH_REGION_LSB-1:0] reg_offs;
    logic                              wr_en;

    assign reg_offs = paddr_i[`SOC_PERIPH_REGION_LSB-1:0];
    assign wr_en    = sel_i & penable_i & pwrite_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fc_bootaddr_o  <= `SOC_PERIPH_BOOT_ADDR_RST;
            fc_fetchen_o   <= 1'b0;
            soc_jtag_reg_o <= '0;
        end else if (wr_en) begin
            case (reg_offs)
                `SOC_PERIPH_CTRL_BOOTADDR: fc_bootaddr_o  <= pwdata_i;
                `SOC_PERIPH_CTRL_FETCHEN:  fc_fetchen_o   <= pwdata_i[0];
                `SOC_PERIPH_CTRL_JTAG:     soc_jtag_reg_o <= pwdata_i[7:0];
                default: ;
            endcase
        end
    end

    // JTAG word has the incoming byte above the outgoing one
    always_comb begin
        case (reg_offs)
            `SOC_PERIPH_CTRL_BOOTADDR: rdata_o = fc_bootaddr_o;
            `SOC_PERIPH_CTRL_FETCHEN:  rdata_o = {31'd0, fc_fetchen_o};
            `SOC_PERIPH_CTRL_JTAG:     rdata_o = {16'd0, soc_jtag_reg_i, soc_jtag_reg_o};
            default:                   rdata_o = '0;
        endcase
    end

endmodule

// ==== hw/gpio_core.sv ====
/*
 * GPIO input path: two-flop synchronizer, per-pin edge detect, sticky status.
 * Pins are assumed to be slower than clk_i; glitches shorter than a cycle may be lost.
 */
`timescale 1ns/10ps

module gpio_core
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  gpio_vec_t gpio_in_i,
    input  gpio_vec_t inten_i,
    input  gpio_vec_t inttype_i,
    input  logic      status_clr_i,

    output gpio_vec_t gpio_sync_o,
    output gpio_vec_t status_o,
    output logic      gpio_event_o
);

    gpio_vec_t sync_meta;
    gpio_vec_t sync_prev;
    gpio_vec_t rise;
    gpio_vec_t fall;
    gpio_vec_t hit;

    ////////////////////
    // Synchronizer
    ////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_meta   <= '0;
            gpio_sync_o <= '0;
            sync_prev   <= '0;
        end else begin
            sync_meta   <= gpio_in_i;
            gpio_sync_o <= sync_meta;
            sync_prev   <= gpio_sync_o;
        end
    end

    ////////////////////
    // Edge detect
    ////////////////////

    assign rise = gpio_sync_o & ~sync_prev;
    assign fall = ~gpio_sync_o & sync_prev;

    // Type 0 picks the rising edge, type 1 the falling edge
    assign hit = inten_i & ((rise & ~inttype_i) | (fall & inttype_i));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_o     <= '0;
            gpio_event_o <= 1'b0;
        end else begin
            // A fresh edge wins over a clear in the same cycle
            if (status_clr_i) begin
                status_o <= hit;
            end else begin
                status_o <= status_o | hit;
            end
            gpio_event_o <= |hit;
        end
    end

endmodule

// ==== hw/gpio_regs.sv ====
/*
 * GPIO register file. Writes land on the edge that ends the access phase.
 * Reading INTSTATUS clears the sticky status in the core.
 */
`timescale 1ns/10ps

`include "soc_periph_settings.svh"

module gpio_regs
    import soc_periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      sel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    input  gpio_vec_t gpio_sync_i,
    input  gpio_vec_t status_i,

    output apb_data_t rdata_o,
    output gpio_vec_t dir_o,
    output gpio_vec_t out_o,
    output gpio_vec_t inten_o,
    output gpio_vec_t inttype_o,
    output logic      status_clr_o
);

    logic [`SOC_PERIPH_REGION_LSB-1:0] reg_offs;
    logic                              wr_en;
    logic                              rd_en;

    // Offset inside the region
    // Region bits are decoded upstream
    assign reg_offs = paddr_i[`SOC_PERIPH_REGION_LSB-1:0];
    assign wr_en    = sel_i & penable_i & pwrite_i;
    assign rd_en    = sel_i & penable_i & ~pwrite_i;

    ////////////////////
    // Write side
    ////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dir_o     <= '0;
            out_o     <= '0;
            inten_o   <= '0;
            inttype_o <= '0;
        end else if (wr_en) begin
            case (reg_offs)
                `SOC_PERIPH_GPIO_DIR:     dir_o     <= pwdata_i;
                `SOC_PERIPH_GPIO_OUT:     out_o     <= pwdata_i;
                `SOC_PERIPH_GPIO_INTEN:   inten_o   <= pwdata_i;
                `SOC_PERIPH_GPIO_INTTYPE: inttype_o <= pwdata_i;
                default: ;
            endcase
        end
    end

    ////////////////////
    // Read side
    ////////////////////

    always_comb begin
        case (reg_offs)
            `SOC_PERIPH_GPIO_DIR:       rdata_o = dir_o;
            `SOC_PERIPH_GPIO_IN:        rdata_o = gpio_sync_i;
            `SOC_PERIPH_GPIO_OUT:       rdata_o = out_o;
            `SOC_PERIPH_GPIO_INTEN:     rdata_o = inten_o;
            `SOC_PERIPH_GPIO_INTTYPE:   rdata_o = inttype_o;
            `SOC_PERIPH_GPIO_INTSTATUS: rdata_o = status_i;
            default:                    rdata_o = '0;
        endcase
    end

    // Clear on read
    // The status word is sampled in the same cycle
    assign status_clr_o = rd_en & (reg_offs == `SOC_PERIPH_GPIO_INTSTATUS);

endmodule

// ==== hw/apb_periph_decoder.sv ====
/*
 * Zero wait state APB decoder for two slaves.
 * Any region other than GPIO or control answers with pslverr and zero data.
 */
`timescale 1ns/10ps

`include "soc_periph_settings.svh"

module apb_periph_decoder
    import soc_periph_pkg::*;
(
    input  apb_addr_t paddr_i,
    input  logic      psel_i,
    input  logic      penable_i,
    input  apb_data_t gpio_rdata_i,
    input  apb_data_t ctrl_rdata_i,

    output logic      gpio_sel_o,
    output logic      ctrl_sel_o,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o
);

    localparam int REGION_W = `SOC_PERIPH_REGION_MSB - `SOC_PERIPH_REGION_LSB + 1;

    logic [REGION_W-1:0] region;
    logic                gpio_hit;
    logic                ctrl_hit;

    ////////////////////
    // Region decode
    ////////////////////

    assign region   = paddr_i[`SOC_PERIPH_REGION_MSB:`SOC_PERIPH_REGION_LSB];
    assign gpio_hit = (region == `SOC_PERIPH_REGION_GPIO);
    assign ctrl_hit = (region == `SOC_PERIPH_REGION_CTRL);

    // Select levels follow psel for the whole transfer
    assign gpio_sel_o = psel_i & gpio_hit;
    assign ctrl_sel_o = psel_i & ctrl_hit;

    ////////////////////
    // Response
    ////////////////////

    // No slave stalls, so every access phase completes
    assign pready_o = 1'b1;

    // Error only in the access phase of an unmapped transfer
    assign pslverr_o = psel_i & penable_i & ~gpio_hit & ~ctrl_hit;

    always_comb begin
        if (gpio_hit) begin
            prdata_o = gpio_rdata_i;
        end else if (ctrl_hit) begin
            prdata_o = ctrl_rdata_i;
        end else begin
            // Unmapped region reads as zero
            prdata_o = '0;
        end
    end

endmodule

// ==== hw/soc_periph_pkg.sv ====
/*
 * Vector types of the SoC peripheral block.
 * Widths come from the settings header.
 */
`include "soc_periph_settings.svh"

package soc_periph_pkg;

    ////////////////////
    // APB
    ////////////////////

    // Byte address on the peripheral bus
    typedef logic [`SOC_PERIPH_APB_AW-1:0] apb_addr_t;

    // One APB data word
    typedef logic [`SOC_PERIPH_APB_DW-1:0] apb_data_t;

    ////////////////////
    // Peripherals
    ////////////////////

    // One bit per GPIO pin
    typedef logic [`SOC_PERIPH_NGPIO-1:0] gpio_vec_t;

    // Event lines into the fabric controller
    typedef logic [31:0] fc_event_vec_t;

    // Byte exchanged with the JTAG side
    typedef logic [7:0] jtag_byte_t;

endpackage

// ==== hw/soc_periph_settings.svh ====
/*
 * Widths, address map and reset values of the SoC peripheral block.
 * Register offsets are byte offsets inside one 4 KiB region.
 */
`ifndef SOC_PERIPH_SETTINGS_SVH
`define SOC_PERIPH_SETTINGS_SVH

`define SOC_PERIPH_APB_AW           32
`define SOC_PERIPH_APB_DW           32
`define SOC_PERIPH_NGPIO            32

// Region select bits of the APB address
`define SOC_PERIPH_REGION_MSB       15
`define SOC_PERIPH_REGION_LSB       12
`define SOC_PERIPH_REGION_GPIO      4'd0
`define SOC_PERIPH_REGION_CTRL      4'd1

// GPIO register offsets
`define SOC_PERIPH_GPIO_DIR         12'h000
`define SOC_PERIPH_GPIO_IN          12'h004
`define SOC_PERIPH_GPIO_OUT         12'h008
`define SOC_PERIPH_GPIO_INTEN       12'h00C
`define SOC_PERIPH_GPIO_INTTYPE     12'h010
`define SOC_PERIPH_GPIO_INTSTATUS   12'h014

// SoC control register offsets
`define SOC_PERIPH_CTRL_BOOTADDR    12'h000
`define SOC_PERIPH_CTRL_FETCHEN     12'h004
`define SOC_PERIPH_CTRL_JTAG        12'h008

`define SOC_PERIPH_BOOT_ADDR_RST    32'h1C00_0080

// Fabric-controller event bit positions
`define SOC_PERIPH_EVT_DMA_PE       8
`define SOC_PERIPH_EVT_DMA_IRQ      9
`define SOC_PERIPH_EVT_PF           12
`define SOC_PERIPH_EVT_REF_CLK      14
`define SOC_PERIPH_EVT_GPIO         15

`endif
